// ==== dmaSettings.svh ====
// Sizing macros shared by the DMA controller RTL.
// Include in any file that sizes a FIFO, an address or a word count.
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// FIFO words, must be a power of two
`define DMA_FIFO_DEPTH 8

// Processor bus address width
`define DMA_ADDR_W 32

// Word count register width
`define DMA_COUNT_W 16

`endif

// ==== dmaBusPkg.sv ====
// Types for the processor-bus side of the DMA controller.
// Used by the bus master FSM and by the register block for the direction bit.
`default_nettype none

package dmaBusPkg;

    // Bus master sequence
    // One pass through address, data and finish per word while the bus is held
    typedef enum logic [2:0] {
        stIdle    = 3'd0,
        stRequest = 3'd1,
        stGrant   = 3'd2,
        stAddress = 3'd3,
        stData    = 3'd4,
        stFinish  = 3'd5,
        stRelease = 3'd6
    } busStateT;

    // Reads fill the FIFO in memToPeriph, writes drain it in periphToMem
    typedef enum logic {
        memToPeriph = 1'b0,
        periphToMem = 1'b1
    } dirT;

endpackage

`default_nettype wire

// ==== dmaRegPkg.sv ====
// Types for the APB register side of the DMA controller.
// Offsets are byte addresses within the register block.
`default_nettype none

package dmaRegPkg;

    // APB register map
    typedef enum logic [3:0] {
        addrReg   = 4'd0,
        countReg  = 4'd4,
        ctrlReg   = 4'd8,
        statusReg = 4'd12
    } regOffsetT;

    // Status register layout, done sits in bit 0
    // Done is write-one-to-clear
    typedef struct packed {
        logic busy;
        logic done;
    } statusT;

endpackage

`default_nettype wire

// ==== dmaIfs.sv ====
// Internal interfaces of the DMA controller.
// dmaFifoIf joins the bus FSM and the peripheral port to the FIFO,
// dmaCountIf joins the bus FSM to the address counter.
`timescale 1ns/1ps
`default_nettype none
`include "dmaSettings.svh"

interface dmaFifoIf;
    logic        push;
    logic [31:0] pushData;
    logic        pop;
    logic [31:0] popData;
    logic        full;
    logic        empty;
    // Second port pair, driven straight from the peripheral pins
    logic        periphPush;
    logic [31:0] periphPushData;
    logic        periphPop;

    modport fifo (
        input  push, pushData, pop, periphPush, periphPushData, periphPop,
        output popData, full, empty
    );
    modport bus (
        output push, pushData, pop,
        input  popData, full, empty
    );
endinterface

interface dmaCountIf;
    logic                   load;
    logic                   step;
    logic [`DMA_ADDR_W-1:0] busAddr;
    logic                   lastWord;

    modport counter (input load, step, output busAddr, lastWord);
    modport control (output load, step, input busAddr, lastWord);
endinterface

`default_nettype wire

// ==== dmaRegs.sv ====
// APB register block of the DMA controller.
// Holds start address, word count and control, reports busy and done,
// and raises the interrupt when done is set and enabled.
`timescale 1ns/1ps
`default_nettype none
`include "dmaSettings.svh"

module dmaRegs (
    input  wire                      BCLK,
    input  wire                      CCRESET_,
    input  wire                      psel,
    input  wire                      penable,
    input  wire                      pwrite,
    input  wire  [3:0]               paddr,
    input  wire  [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     startPulse,
    output dmaBusPkg::dirT           dir,
    output logic [`DMA_ADDR_W-1:0]   startAddr,
    output logic [`DMA_COUNT_W-1:0]  wordCount,
    input  wire                      busy,
    input  wire                      donePulse,
    output logic                     irq
);
    // Control register bits
    localparam int startBit = 0;
    localparam int dirBit   = 1;
    localparam int irqEnBit = 2;

    dmaRegPkg::regOffsetT offset;
    dmaRegPkg::statusT    status;
    logic                 wrAccess;
    logic                 irqEn;
    logic                 doneBit;

    assign offset   = dmaRegPkg::regOffsetT'(paddr);
    assign wrAccess = psel && penable && pwrite;
    assign status   = '{busy: busy, done: doneBit};
    assign irq      = doneBit && irqEn;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            startAddr  <= '0;
            wordCount  <= '0;
            dir        <= dmaBusPkg::memToPeriph;
            irqEn      <= 1'b0;
            startPulse <= 1'b0;
            doneBit    <= 1'b0;
        end else begin
            // Start is not stored, it only fires for one cycle
            startPulse <= wrAccess && (offset == dmaRegPkg::ctrlReg) && pwdata[startBit];
            if (wrAccess) begin
                case (offset)
                    dmaRegPkg::addrReg:  startAddr <= pwdata[`DMA_ADDR_W-1:0];
                    dmaRegPkg::countReg: wordCount <= pwdata[`DMA_COUNT_W-1:0];
                    dmaRegPkg::ctrlReg: begin
                        dir   <= dmaBusPkg::dirT'(pwdata[dirBit]);
                        irqEn <= pwdata[irqEnBit];
                    end
                    default: ;
                endcase
            end
            // A new completion wins over a clear in the same cycle
            if (donePulse) begin
                doneBit <= 1'b1;
            end else if (wrAccess && (offset == dmaRegPkg::statusReg) && pwdata[0]) begin
                doneBit <= 1'b0;
            end
        end
    end

    always_comb begin
        case (offset)
            dmaRegPkg::addrReg:   prdata = 32'(startAddr);
            dmaRegPkg::countReg:  prdata = 32'(wordCount);
            dmaRegPkg::ctrlReg:   prdata = {29'b0, irqEn, dir, 1'b0};
            dmaRegPkg::statusReg: prdata = 32'(status);
            default:              prdata = '0;
        endcase
    end
endmodule

`default_nettype wire

// ==== dmaFifo.sv ====
// Word FIFO between the processor bus and the peripheral port.
// Either side may push or pop, but only one writer and one reader per direction.
`timescale 1ns/1ps
`default_nettype none
`include "dmaSettings.svh"

module dmaFifo (
    input wire     BCLK,
    input wire     CCRESET_,
    dmaFifoIf.fifo fifo
);
    localparam int ptrW = $clog2(`DMA_FIFO_DEPTH);
    localparam logic [ptrW:0] fullCount = `DMA_FIFO_DEPTH;

    logic [31:0]     mem [`DMA_FIFO_DEPTH];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW:0]   used;
    logic            wrEn;
    logic            rdEn;
    logic [31:0]     wrData;

    // Peripheral side completes only when its ready or valid is high
    assign wrEn   = fifo.push || (fifo.periphPush && !fifo.full);
    assign rdEn   = fifo.pop || (fifo.periphPop && !fifo.empty);
    assign wrData = fifo.push ? fifo.pushData : fifo.periphPushData;

    assign fifo.full    = (used == fullCount);
    assign fifo.empty   = (used == '0);
    assign fifo.popData = mem[rdPtr];

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wrPtr <= '0;
            rdPtr <= '0;
            used  <= '0;
        end else begin
            if (wrEn) wrPtr <= wrPtr + 1'b1;
            if (rdEn) rdPtr <= rdPtr + 1'b1;
            case ({wrEn, rdEn})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge BCLK) begin
        if (wrEn) mem[wrPtr] <= wrData;
    end

    // The bus FSM only starts a word when the FIFO has room or data for it
    noPushFull: assert property (@(posedge BCLK) disable iff (!CCRESET_)
        fifo.push |-> !fifo.full) else $error("FIFO push while full");
    noPopEmpty: assert property (@(posedge BCLK) disable iff (!CCRESET_)
        fifo.pop |-> !fifo.empty) else $error("FIFO pop while empty");
    oneSidePerDir: assert property (@(posedge BCLK) disable iff (!CCRESET_)
        !(fifo.push && fifo.periphPush) && !(fifo.pop && fifo.periphPop))
        else $error("Bus and peripheral use the same FIFO port");
endmodule

`default_nettype wire

// ==== dmaAddrCounter.sv ====
// Bus address and remaining word count of a DMA transfer.
// Loaded at start, stepped once per finished bus cycle.
`timescale 1ns/1ps
`default_nettype none
`include "dmaSettings.svh"

module dmaAddrCounter (
    input wire                     BCLK,
    input wire                     CCRESET_,
    input wire [`DMA_ADDR_W-1:0]   startAddr,
    input wire [`DMA_COUNT_W-1:0]  wordCount,
    dmaCountIf.counter             cnt
);
    logic [`DMA_ADDR_W-1:0]  addr;
    logic [`DMA_COUNT_W-1:0] remaining;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            addr      <= '0;
            remaining <= '0;
        end else if (cnt.load) begin
            addr      <= startAddr;
            remaining <= wordCount;
        end else if (cnt.step) begin
            // Longword steps on a 32-bit bus
            addr      <= addr + `DMA_ADDR_W'(4);
            remaining <= remaining - 1'b1;
        end
    end

    assign cnt.busAddr  = addr;
    // Still counts the word in flight, so this marks the final bus cycle
    assign cnt.lastWord = (remaining == `DMA_COUNT_W'(1));
endmodule

`default_nettype wire

// ==== cpuBusSm.sv ====
// Bus master FSM for a 68030-style processor bus.
// Requests the bus, runs one longword cycle per word, ends it on DSACK or STERM,
// and moves the word between the bus and the FIFO.
`timescale 1ns/1ps
`default_nettype none

module cpuBusSm (
    input  wire                 BCLK,
    input  wire                 CCRESET_,
    input  wire                 startPulse,
    input  wire dmaBusPkg::dirT dir,
    output logic                busy,
    output logic                donePulse,
    input  wire                 busGrantN,
    input  wire                 asInN,
    input  wire  [1:0]          dsackN,
    input  wire                 stermN,
    output logic                breq,
    output logic                bgack,
    output logic                asN,
    output logic                dsN,
    output logic                busRw,
    input  wire  [31:0]         dataIn,
    output logic [31:0]         dataOut,
    dmaFifoIf.bus               fifo,
    dmaCountIf.control          cnt
);
    dmaBusPkg::busStateT state;
    dmaBusPkg::dirT      xferDir;
    dmaBusPkg::dirT      curDir;
    logic                grantSyncN;
    logic                asInSyncN;
    logic                stermSyncN;
    logic [1:0]          dsackSyncN;
    logic [31:0]         readData;
    logic                room;
    logic                termSeen;

    // Asynchronous bus inputs pass one flop
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            grantSyncN <= 1'b1;
            asInSyncN  <= 1'b1;
            stermSyncN <= 1'b1;
            dsackSyncN <= 2'b11;
        end else begin
            grantSyncN <= busGrantN;
            asInSyncN  <= asInN;
            stermSyncN <= stermN;
            dsackSyncN <= dsackN;
        end
    end

    // 32-bit port only, so both DSACK lines or STERM end the cycle
    assign termSeen = (dsackSyncN == 2'b00) || !stermSyncN;
    assign curDir   = (state == dmaBusPkg::stIdle) ? dir : xferDir;
    // Space for a read word or data for a write word
    assign room     = (curDir == dmaBusPkg::memToPeriph) ? !fifo.full : !fifo.empty;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state     <= dmaBusPkg::stIdle;
            xferDir   <= dmaBusPkg::memToPeriph;
            busy      <= 1'b0;
            donePulse <= 1'b0;
            breq      <= 1'b0;
            bgack     <= 1'b0;
            asN       <= 1'b1;
            dsN       <= 1'b1;
            busRw     <= 1'b1;
        end else begin
            donePulse <= 1'b0;
            case (state)
                dmaBusPkg::stIdle: if (startPulse) begin
                    xferDir <= dir;
                    busy    <= 1'b1;
                    breq    <= room;
                    state   <= dmaBusPkg::stRequest;
                end
                dmaBusPkg::stRequest: begin
                    if (!breq) begin
                        breq <= room;
                    end else if (!grantSyncN && asInSyncN) begin
                        // Take the bus once the previous master has let go of AS
                        breq  <= 1'b0;
                        bgack <= 1'b1;
                        state <= dmaBusPkg::stGrant;
                    end
                end
                dmaBusPkg::stGrant: begin
                    if (room) begin
                        asN   <= 1'b0;
                        busRw <= (xferDir == dmaBusPkg::memToPeriph);
                        state <= dmaBusPkg::stAddress;
                    end else begin
                        bgack <= 1'b0;
                        state <= dmaBusPkg::stRelease;
                    end
                end
                dmaBusPkg::stAddress: begin
                    dsN   <= 1'b0;
                    state <= dmaBusPkg::stData;
                end
                dmaBusPkg::stData: if (termSeen) begin
                    asN   <= 1'b1;
                    dsN   <= 1'b1;
                    state <= dmaBusPkg::stFinish;
                end
                dmaBusPkg::stFinish: begin
                    if (cnt.lastWord) begin
                        bgack     <= 1'b0;
                        busy      <= 1'b0;
                        donePulse <= 1'b1;
                        state     <= dmaBusPkg::stRelease;
                    end else begin
                        // Hold the bus and recheck the FIFO in grant
                        state <= dmaBusPkg::stGrant;
                    end
                end
                dmaBusPkg::stRelease: begin
                    state <= busy ? dmaBusPkg::stRequest : dmaBusPkg::stIdle;
                end
                default: state <= dmaBusPkg::stIdle;
            endcase
        end
    end

    // Read data latched on the terminating edge, write data taken from the FIFO head
    always_ff @(posedge BCLK) begin
        if (state == dmaBusPkg::stData && termSeen) readData <= dataIn;
        if (state == dmaBusPkg::stGrant) dataOut <= fifo.popData;
    end

    assign cnt.load      = (state == dmaBusPkg::stIdle) && startPulse;
    assign cnt.step      = (state == dmaBusPkg::stFinish);
    assign fifo.push     = (state == dmaBusPkg::stFinish) && (xferDir == dmaBusPkg::memToPeriph);
    assign fifo.pushData = readData;
    assign fifo.pop      = (state == dmaBusPkg::stFinish) && (xferDir == dmaBusPkg::periphToMem);

    asOnlyWithBgack: assert property (@(posedge BCLK) disable iff (!CCRESET_)
        !asN |-> bgack) else $error("AS driven without bus ownership");
    breqBgackOverlap: assert property (@(posedge BCLK) disable iff (!CCRESET_)
        (breq && bgack) |=> !(breq && bgack)) else $error("BR and BGACK overlap too long");
    addrStable: assert property (@(posedge BCLK) disable iff (!CCRESET_)
        !asN |=> asN || $stable(cnt.busAddr)) else $error("Address moved during a bus cycle");
endmodule

`default_nettype wire

// ==== dmaTop.sv ====
// Top level of the DMA controller: APB registers, bus master, address counter
// and FIFO. The peripheral drives only the port that matches the direction.
`timescale 1ns/1ps
`default_nettype none
`include "dmaSettings.svh"

module dmaTop (
    input  wire                    BCLK,
    input  wire                    CCRESET_,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire  [3:0]             paddr,
    input  wire  [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   irq,
    input  wire                    busGrantN,
    input  wire                    asInN,
    input  wire  [1:0]             dsackN,
    input  wire                    stermN,
    output logic                   breq,
    output logic                   bgack,
    output logic                   asN,
    output logic                   dsN,
    output logic                   busRw,
    output logic [`DMA_ADDR_W-1:0] busAddr,
    input  wire  [31:0]            dataIn,
    output logic [31:0]            dataOut,
    input  wire                    periphWrValid,
    input  wire  [31:0]            periphWrData,
    output logic                   periphWrReady,
    output logic                   periphRdValid,
    output logic [31:0]            periphRdData,
    input  wire                    periphRdReady
);
    logic                    startPulse;
    dmaBusPkg::dirT          dir;
    logic [`DMA_ADDR_W-1:0]  startAddr;
    logic [`DMA_COUNT_W-1:0] wordCount;
    logic                    busy;
    logic                    donePulse;

    dmaFifoIf  fifoIf ();
    dmaCountIf countIf ();

    // Peripheral pins go straight to the FIFO's second port pair
    assign fifoIf.periphPush     = periphWrValid;
    assign fifoIf.periphPushData = periphWrData;
    assign fifoIf.periphPop      = periphRdReady;
    assign periphWrReady         = !fifoIf.full;
    assign periphRdValid         = !fifoIf.empty;
    assign periphRdData          = fifoIf.popData;
    assign busAddr               = countIf.busAddr;

    dmaRegs regs0 (
        .BCLK, .CCRESET_, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .startPulse, .dir, .startAddr, .wordCount, .busy, .donePulse, .irq
    );

    dmaFifo fifo0 (.BCLK, .CCRESET_, .fifo(fifoIf.fifo));

    dmaAddrCounter counter0 (.BCLK, .CCRESET_, .startAddr, .wordCount, .cnt(countIf.counter));

    cpuBusSm busSm0 (
        .BCLK, .CCRESET_, .startPulse, .dir, .busy, .donePulse,
        .busGrantN, .asInN, .dsackN, .stermN,
        .breq, .bgack, .asN, .dsN, .busRw, .dataIn, .dataOut,
        .fifo(fifoIf.bus), .cnt(countIf.control)
    );
endmodule

`default_nettype wire

// ==== tbBusMemory.sv ====
// Processor bus memory and arbiter model for the DMA testbench.
// Grants the bus and terminates cycles after random delays, by DSACK or STERM.
`timescale 1ns/1ps
`default_nettype none
`include "dmaSettings.svh"

module tbBusMemory (
    input  wire                    BCLK,
    input  wire                    CCRESET_,
    input  wire                    grantEnable,
    input  wire                    breq,
    input  wire                    bgack,
    input  wire                    asN,
    input  wire                    dsN,
    input  wire                    busRw,
    input  wire  [`DMA_ADDR_W-1:0] busAddr,
    input  wire  [31:0]            dataOut,
    output logic                   busGrantN,
    output logic                   asInN,
    output logic [1:0]             dsackN,
    output logic                   stermN,
    output logic [31:0]            dataIn
);
    // 64 longwords starting at byte address 0x1000
    logic [31:0] mem [64];
    logic [1:0]  grantWait;
    logic [1:0]  ackWait;
    logic [5:0]  idx;

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return {~addr[15:0], addr[15:0]} ^ {addr[31:16], 16'h5A5A};
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = fillWord(32'h1000 + 32'(i) * 4);
        end
    end

    assign idx = busAddr[7:2];

    always @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            busGrantN <= 1'b1;
            asInN     <= 1'b1;
            dsackN    <= 2'b11;
            stermN    <= 1'b1;
            dataIn    <= '0;
            grantWait <= 2'd0;
            ackWait   <= 2'd0;
        end else begin
            // No other master here, so the external AS follows ours
            asInN <= asN;
            if (bgack) begin
                busGrantN <= 1'b1;
            end else if (!breq) begin
                grantWait <= 2'($urandom % 4);
            end else if (grantWait != 0) begin
                grantWait <= grantWait - 1'b1;
            end else if (grantEnable) begin
                busGrantN <= 1'b0;
            end
            if (asN || dsN) begin
                dsackN  <= 2'b11;
                stermN  <= 1'b1;
                ackWait <= 2'($urandom % 4);
            end else if (ackWait != 0) begin
                ackWait <= ackWait - 1'b1;
            end else if (dsackN == 2'b11 && stermN) begin
                if ($urandom % 2 == 0) dsackN <= 2'b00;
                else stermN <= 1'b0;
                if (busRw) dataIn <= mem[idx];
                else mem[idx] <= dataOut;
            end
        end
    end
endmodule

`default_nettype wire

// ==== tbDmaTop.sv ====
// Testbench for the DMA controller covering APB setup, both directions,
// random peripheral stalls, status and interrupt, and held grant.
`timescale 1ns/1ps
`default_nettype none
`include "dmaSettings.svh"

module tbDmaTop;
    logic BCLK = 1'b0;
    logic CCRESET_;
    logic psel, penable, pwrite;
    logic [3:0] paddr;
    logic [31:0] pwdata, prdata;
    logic irq, busGrantN, asInN, stermN, breq, bgack, asN, dsN, busRw;
    logic [1:0] dsackN;
    logic [`DMA_ADDR_W-1:0] busAddr;
    logic [31:0] dataIn, dataOut, periphWrData, periphRdData;
    logic periphWrValid, periphWrReady, periphRdValid, periphRdReady;
    logic grantEnable;
    logic rxEn, txEn, holdGrant, xferIdle, asPrev;
    logic [31:0] rxQ[$];
    logic [`DMA_ADDR_W-1:0] addrQ[$];
    logic [31:0] txData[$];
    int txIdx;

    dmaTop dut0 (.*);

    tbBusMemory bus0 (
        .BCLK, .CCRESET_, .grantEnable, .breq, .bgack, .asN, .dsN, .busRw, .busAddr,
        .dataOut, .busGrantN, .asInN, .dsackN, .stermN, .dataIn
    );

    always #50 BCLK = ~BCLK;

    // Same fill rule as the bus model memory
    function automatic logic [31:0] expectedWord(input logic [31:0] addr);
        return {~addr[15:0], addr[15:0]} ^ {addr[31:16], 16'h5A5A};
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            failRun($sformatf("** Error at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic checkAddr(input string name, input logic [`DMA_ADDR_W-1:0] got,
                             input logic [`DMA_ADDR_W-1:0] exp);
        if (got !== exp)
            failRun($sformatf("** Error at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic checkStatus(input string name, input dmaRegPkg::statusT got,
                               input dmaRegPkg::statusT exp);
        if (got !== exp)
            failRun($sformatf("** Error at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic apbWrite(input dmaRegPkg::regOffsetT off, input logic [31:0] data);
        @(posedge BCLK);
        psel <= 1'b1;
        pwrite <= 1'b1;
        paddr <= off;
        pwdata <= data;
        @(posedge BCLK);
        penable <= 1'b1;
        @(posedge BCLK);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic apbRead(input dmaRegPkg::regOffsetT off, output logic [31:0] data);
        @(posedge BCLK);
        psel <= 1'b1;
        pwrite <= 1'b0;
        paddr <= off;
        @(posedge BCLK);
        penable <= 1'b1;
        @(negedge BCLK);
        data = prdata;
        @(posedge BCLK);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic readStatus(output dmaRegPkg::statusT st);
        logic [31:0] data;
        apbRead(dmaRegPkg::statusReg, data);
        st = dmaRegPkg::statusT'(data[1:0]);
    endtask

    // Polls status until done or the poll limit
    task automatic waitDone();
        dmaRegPkg::statusT st;
        int polls;
        polls = 0;
        readStatus(st);
        while (!st.done) begin
            polls++;
            if (polls > 300) failRun("Timeout waiting for the transfer to finish");
            readStatus(st);
        end
    endtask

    task automatic startXfer(input logic [31:0] addr, input int count, input logic p2m,
                             input logic irqOn);
        apbWrite(dmaRegPkg::addrReg, addr);
        apbWrite(dmaRegPkg::countReg, 32'(count));
        xferIdle = 1'b0;
        apbWrite(dmaRegPkg::ctrlReg, {29'b0, irqOn, p2m, 1'b1});
    endtask

    task automatic clearDone();
        dmaRegPkg::statusT st;
        apbWrite(dmaRegPkg::statusReg, 32'h1);
        readStatus(st);
        checkStatus("status after clear", st, '0);
        @(negedge BCLK);
        checkWord("irq after clear", 32'(irq), 32'h0);
    endtask

    // Peripheral side with random stalls
    always @(posedge BCLK) begin
        if (CCRESET_) begin
            if (periphRdValid && periphRdReady) rxQ.push_back(periphRdData);
            periphRdReady <= rxEn && ($urandom % 3 != 0);
            if (periphWrValid && periphWrReady) begin
                txIdx = txIdx + 1;
            end
            periphWrValid <= txEn && (txIdx < txData.size()) && ($urandom % 3 != 0);
            periphWrData  <= (txIdx < txData.size()) ? txData[txIdx] : 32'h0;
        end
    end

    // Bus monitor samples on the falling edge where outputs are stable
    always @(negedge BCLK) begin
        if (CCRESET_) begin
            if (asPrev && !asN) addrQ.push_back(busAddr);
            if (holdGrant && !asN) failRun("Address strobe fell while the grant was withheld");
            if (xferIdle && bgack) failRun("Bus grant acknowledge high while idle");
        end
        asPrev = asN;
    end

    initial begin
        logic [31:0] data;
        dmaRegPkg::statusT st;
        int seed;
        int waitCycles;
        seed = $urandom(18);
        CCRESET_ = 1'b0;
        psel = 0;
        penable = 0;
        pwrite = 0;
        paddr = '0;
        pwdata = '0;
        periphWrValid = 0;
        periphWrData = '0;
        periphRdReady = 0;
        grantEnable = 1;
        rxEn = 0;
        txEn = 0;
        holdGrant = 0;
        xferIdle = 1;
        asPrev = 1;
        txIdx = 0;
        repeat (5) @(posedge BCLK);
        CCRESET_ <= 1'b1;

        // Register access
        readStatus(st);
        checkStatus("status after reset", st, '0);
        apbWrite(dmaRegPkg::addrReg, 32'h1234_5678);
        apbWrite(dmaRegPkg::countReg, 32'h0000_ABCD);
        apbWrite(dmaRegPkg::ctrlReg, 32'h6);
        apbRead(dmaRegPkg::addrReg, data);
        checkWord("addrReg", data, 32'h1234_5678);
        apbRead(dmaRegPkg::countReg, data);
        checkWord("countReg", data, 32'h0000_ABCD);
        apbRead(dmaRegPkg::ctrlReg, data);
        checkWord("ctrlReg", data, 32'h6);
        readStatus(st);
        checkStatus("status before start", st, '0);

        // Memory to peripheral, 12 words
        rxEn = 1;
        addrQ.delete();
        startXfer(32'h1010, 12, 1'b0, 1'b1);
        waitDone();
        xferIdle = 1'b1;
        waitCycles = 0;
        while (rxQ.size() < 12) begin
            @(posedge BCLK);
            waitCycles++;
            if (waitCycles > 200) failRun("Timeout waiting for peripheral words");
        end
        // All words delivered, so nothing may be left to read
        @(negedge BCLK);
        checkWord("periphRdValid", 32'(periphRdValid), 32'h0);
        if (rxQ.size() != 12 || addrQ.size() != 12)
            failRun($sformatf("Word count mismatch, %0d received, %0d bus cycles",
                              rxQ.size(), addrQ.size()));
        for (int i = 0; i < 12; i++) begin
            checkWord("periphRdData", rxQ[i], expectedWord(32'h1010 + 32'(i) * 4));
            checkAddr("busAddr", addrQ[i], 32'h1010 + 32'(i) * 4);
        end
        readStatus(st);
        checkStatus("status after read transfer", st, '{busy: 1'b0, done: 1'b1});
        @(negedge BCLK);
        checkWord("irq enabled", 32'(irq), 32'h1);
        clearDone();
        rxEn = 0;

        // Peripheral to memory, 10 words
        for (int i = 0; i < 10; i++) txData.push_back($urandom);
        txIdx = 0;
        txEn = 1;
        startXfer(32'h1080, 10, 1'b1, 1'b0);
        waitDone();
        xferIdle = 1'b1;
        readStatus(st);
        checkStatus("status after write transfer", st, '{busy: 1'b0, done: 1'b1});
        @(negedge BCLK);
        checkWord("irq disabled", 32'(irq), 32'h0);
        for (int i = 0; i < 10; i++)
            checkWord("memory word", bus0.mem[6'(32 + i)], txData[i]);
        clearDone();
        txEn = 0;

        // Grant withheld, then released
        grantEnable <= 1'b0;
        holdGrant = 1'b1;
        rxEn = 1;
        rxQ.delete();
        startXfer(32'h1000, 1, 1'b0, 1'b0);
        repeat (30) @(posedge BCLK);
        holdGrant = 1'b0;
        grantEnable <= 1'b1;
        waitDone();
        xferIdle = 1'b1;
        waitCycles = 0;
        while (rxQ.size() < 1) begin
            @(posedge BCLK);
            waitCycles++;
            if (waitCycles > 200) failRun("Timeout waiting for the single peripheral word");
        end
        @(negedge BCLK);
        checkWord("periphRdValid", 32'(periphRdValid), 32'h0);
        if (rxQ.size() != 1) failRun("Single word transfer did not deliver one word");
        checkWord("periphRdData", rxQ[0], expectedWord(32'h1000));
        clearDone();

        $display("*** TEST PASSED ***");
        $finish;
    end

    // Overall run limit
    initial begin
        #2ms;
        $display("Simulation time limit reached");
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout");
    end
endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
dmaBusPkg.sv
dmaRegPkg.sv
dmaIfs.sv
dmaRegs.sv
dmaFifo.sv
dmaAddrCounter.sv
cpuBusSm.sv
dmaTop.sv
tbBusMemory.sv
tbDmaTop.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the DMA testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f build.f --top-module tbDmaTop -o simDma
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simDma > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
